/* hw/rvga_pkg.sv */
package rvga_pkg;

  typedef logic [31:0] rvga_word;
  typedef logic [4:0]  rvga_reg;

  typedef enum logic [6:0] {
    e_rvga_opcode_op     = 7'b0110011,
    e_rvga_opcode_op_imm = 7'b0010011,
    e_rvga_opcode_lui    = 7'b0110111,
    e_rvga_opcode_br     = 7'b1100011,
    e_rvga_opcode_store  = 7'b0100011,
    e_rvga_opcode_load   = 7'b0000011,
    e_rvga_opcode_jal    = 7'b1101111,
    e_rvga_opcode_jalr   = 7'b1100111
  } rvga_opcode_e;

  // Arithmetic operation as encoded in funct3
  typedef enum logic [2:0] {
    e_rvga_artop_add  = 3'b000,
    e_rvga_artop_sll  = 3'b001,
    e_rvga_artop_slt  = 3'b010,
    e_rvga_artop_sltu = 3'b011,
    e_rvga_artop_xor  = 3'b100,
    e_rvga_artop_srx  = 3'b101,
    e_rvga_artop_or   = 3'b110,
    e_rvga_artop_and  = 3'b111
  } rvga_artop_e;

  typedef struct packed {
    logic [6:0] funct7;
    rvga_reg    rs2;
    rvga_reg    rs1;
    logic [2:0] funct3;
    rvga_reg    rd;
    logic [6:0] opcode;
  } rvga_inst_r_s;

  typedef struct packed {
    logic [11:0] imm_11_0;
    rvga_reg     rs1;
    logic [2:0]  funct3;
    rvga_reg     rd;
    logic [6:0]  opcode;
  } rvga_inst_i_s;

  typedef struct packed {
    logic [6:0] imm_11_5;
    rvga_reg    rs2;
    rvga_reg    rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } rvga_inst_s_s;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    rvga_reg    rs2;
    rvga_reg    rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } rvga_inst_b_s;

  typedef struct packed {
    logic [19:0] imm_31_12;
    rvga_reg     rd;
    logic [6:0]  opcode;
  } rvga_inst_u_s;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    rvga_reg    rd;
    logic [6:0] opcode;
  } rvga_inst_j_s;

  typedef union packed {
    rvga_inst_r_s r;
    rvga_inst_i_s i;
    rvga_inst_s_s s;
    rvga_inst_b_s b;
    rvga_inst_u_s u;
    rvga_inst_j_s j;
  } rvga_inst_u;

endpackage : rvga_pkg

/* hw/rvga_ifs.sv */
`timescale 1ns/1ps

// Decoded instruction from decode_stage to reg_fetch
interface dec_if;
  import rvga_pkg::*;

  logic        valid;
  rvga_reg     rs1;
  rvga_reg     rs2;
  rvga_reg     rd;
  rvga_word    imm;
  logic        imm_v;      // Second operand is the immediate
  logic        lui;        // First operand forced to zero
  rvga_artop_e artop;
  logic        alt_art;    // Subtract or arithmetic shift right
  logic        illegal;

  modport src (output valid, rs1, rs2, rd, imm, imm_v, lui, artop, alt_art, illegal);
  modport dst (input  valid, rs1, rs2, rd, imm, imm_v, lui, artop, alt_art, illegal);
endinterface : dec_if

// Resolved operands from reg_fetch to alu_execute
interface exe_if;
  import rvga_pkg::*;

  logic        valid;
  logic        illegal;
  rvga_reg     rd;
  rvga_word    op_a;
  rvga_word    op_b;
  rvga_artop_e artop;
  logic        alt_art;

  modport src (output valid, illegal, rd, op_a, op_b, artop, alt_art);
  modport dst (input  valid, illegal, rd, op_a, op_b, artop, alt_art);
endinterface : exe_if

/* hw/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              instr_valid,
  input  rvga_pkg::rvga_word instr,
  dec_if.src                dec
);
  import rvga_pkg::*;

  rvga_inst_u   inst;
  rvga_opcode_e opcode;
  rvga_artop_e  artop;
  rvga_word     imm;
  logic         legal;
  logic         imm_v;
  logic         lui;
  logic         alt_art;

  assign inst   = instr;
  assign opcode = rvga_opcode_e'(inst.r.opcode);

  always_comb begin
    legal   = 1'b1;
    imm_v   = 1'b0;
    lui     = 1'b0;
    alt_art = 1'b0;
    artop   = rvga_artop_e'(inst.r.funct3);
    imm     = '0;
    case (opcode)
      e_rvga_opcode_op: begin
        alt_art = inst.r.funct7[5];  // Bit 30 selects sub and sra
      end
      e_rvga_opcode_op_imm: begin
        imm_v = 1'b1;
        if (artop == e_rvga_artop_sll || artop == e_rvga_artop_srx) begin
          imm     = {27'b0, inst.i.imm_11_0[4:0]};  // Only the shamt
          alt_art = (artop == e_rvga_artop_srx) && inst.i.imm_11_0[10];
        end else begin
          imm = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
        end
      end
      e_rvga_opcode_lui: begin
        lui   = 1'b1;
        imm_v = 1'b1;
        artop = e_rvga_artop_add;
        imm   = {inst.u.imm_31_12, 12'b0};
      end
      default: legal = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec.valid   <= 1'b0;
      dec.illegal <= 1'b0;
    end else begin
      dec.valid   <= instr_valid && legal;
      dec.illegal <= instr_valid && !legal;
    end
  end

  always_ff @(posedge clk) begin
    dec.rs1     <= inst.r.rs1;
    dec.rs2     <= inst.r.rs2;
    dec.rd      <= inst.r.rd;
    dec.imm     <= imm;
    dec.imm_v   <= imm_v;
    dec.lui     <= lui;
    dec.artop   <= artop;
    dec.alt_art <= alt_art;
  end

endmodule : decode_stage

/* hw/reg_fetch.sv */
`timescale 1ns/1ps

module reg_fetch #(
  parameter int NUM_REGS = 32
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               wb_valid,
  input  rvga_pkg::rvga_reg  wb_rd,
  input  rvga_pkg::rvga_word wb_data,
  dec_if.dst                 dec,
  exe_if.src                 exe
);
  import rvga_pkg::*;

  localparam int IDX_W = $clog2(NUM_REGS);

  rvga_word regs [NUM_REGS];
  rvga_word rs1_val;
  rvga_word rs2_val;
  rvga_word op_a;
  rvga_word op_b;
  logic     wb_en;

  // Registers above NUM_REGS do not exist in RV32E and stay unwritten
  assign wb_en = wb_valid && (wb_rd != '0) && (int'(wb_rd) < NUM_REGS);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en) begin
      regs[wb_rd[IDX_W-1:0]] <= wb_data;
    end
  end

  // Bypass covers the instruction one position ahead, still in the ALU
  function automatic rvga_word read_operand(input rvga_reg rs);
    rvga_word val;
    if (rs == '0) begin
      val = '0;
    end else if (wb_valid && rs == wb_rd) begin
      val = wb_data;
    end else if (int'(rs) < NUM_REGS) begin
      val = regs[rs[IDX_W-1:0]];
    end else begin
      val = '0;
    end
    return val;
  endfunction

  always_comb begin
    rs1_val = read_operand(dec.rs1);
    rs2_val = read_operand(dec.rs2);
    op_a    = dec.lui ? '0 : rs1_val;
    op_b    = dec.imm_v ? dec.imm : rs2_val;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exe.valid   <= 1'b0;
      exe.illegal <= 1'b0;
    end else begin
      exe.valid   <= dec.valid;
      exe.illegal <= dec.illegal;
    end
  end

  always_ff @(posedge clk) begin
    exe.rd      <= dec.rd;
    exe.op_a    <= op_a;
    exe.op_b    <= op_b;
    exe.artop   <= dec.artop;
    exe.alt_art <= dec.alt_art;
  end

endmodule : reg_fetch

/* hw/alu_execute.sv */
`timescale 1ns/1ps

module alu_execute (
  input  logic               clk,
  input  logic               rst_n,
  exe_if.dst                 exe,
  output logic               wb_valid,
  output rvga_pkg::rvga_reg  wb_rd,
  output rvga_pkg::rvga_word wb_data,
  output logic               result_valid,
  output rvga_pkg::rvga_reg  result_rd,
  output rvga_pkg::rvga_word result_data,
  output logic               illegal
);
  import rvga_pkg::*;

  rvga_word   alu_res;
  logic [4:0] shamt;

  assign shamt = exe.op_b[4:0];

  always_comb begin
    case (exe.artop)
      e_rvga_artop_add: begin
        alu_res = exe.alt_art ? exe.op_a - exe.op_b : exe.op_a + exe.op_b;
      end
      e_rvga_artop_sll: begin
        alu_res = exe.op_a << shamt;
      end
      e_rvga_artop_slt: begin
        alu_res = {31'b0, $signed(exe.op_a) < $signed(exe.op_b)};
      end
      e_rvga_artop_sltu: begin
        alu_res = {31'b0, exe.op_a < exe.op_b};
      end
      e_rvga_artop_xor: begin
        alu_res = exe.op_a ^ exe.op_b;
      end
      e_rvga_artop_srx: begin
        if (exe.alt_art) begin
          alu_res = $unsigned($signed(exe.op_a) >>> shamt);  // Sign fills from the left
        end else begin
          alu_res = exe.op_a >> shamt;
        end
      end
      e_rvga_artop_or: begin
        alu_res = exe.op_a | exe.op_b;
      end
      default: begin
        alu_res = exe.op_a & exe.op_b;
      end
    endcase
  end

  // Write-back goes out in the same cycle so reg_fetch can bypass it
  assign wb_valid = exe.valid && (exe.rd != '0);
  assign wb_rd    = exe.rd;
  assign wb_data  = alu_res;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
      illegal      <= 1'b0;
    end else begin
      result_valid <= exe.valid;
      illegal      <= exe.illegal;
    end
  end

  always_ff @(posedge clk) begin
    result_rd   <= exe.rd;
    result_data <= alu_res;
  end

endmodule : alu_execute

/* hw/rvga_core.sv */
`timescale 1ns/1ps

module rvga_core #(
  parameter int NUM_REGS = 32  // 16 for RV32E
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               instr_valid,
  input  rvga_pkg::rvga_word instr,
  output logic               result_valid,
  output rvga_pkg::rvga_reg  result_rd,
  output rvga_pkg::rvga_word result_data,
  output logic               illegal
);
  import rvga_pkg::*;

  logic     wb_valid;
  rvga_reg  wb_rd;
  rvga_word wb_data;

  dec_if dec_bus ();
  exe_if exe_bus ();

  decode_stage i_decode_stage (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .dec         (dec_bus.src)
  );

  reg_fetch #(
    .NUM_REGS (NUM_REGS)
  ) i_reg_fetch (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_valid (wb_valid),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data),
    .dec      (dec_bus.dst),
    .exe      (exe_bus.src)
  );

  alu_execute i_alu_execute (
    .clk          (clk),
    .rst_n        (rst_n),
    .exe          (exe_bus.dst),
    .wb_valid     (wb_valid),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data),
    .result_valid (result_valid),
    .result_rd    (result_rd),
    .result_data  (result_data),
    .illegal      (illegal)
  );

endmodule : rvga_core

/* testbench/tb_rvga_core.sv */
`timescale 1ns/1ps

module tb_rvga_core;
  import rvga_pkg::*;

  localparam int CLK_PERIOD  = 4;
  localparam int MAX_RECORDS = 64;

  typedef struct packed {
    logic     illegal;
    rvga_reg  rd;
    rvga_word data;
  } exp_entry_t;

  logic     clk;
  logic     rst_n;
  logic     instr_valid;
  rvga_word instr;
  logic     result_valid;
  rvga_reg  result_rd;
  rvga_word result_data;
  logic     illegal;

  rvga_word   stim_mem [4*MAX_RECORDS];  // Four words per record
  exp_entry_t exp_q [$];
  int         num_lines = 0;

  rvga_core #(
    .NUM_REGS (32)
  ) i_rvga_core (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .result_valid (result_valid),
    .result_rd    (result_rd),
    .result_data  (result_data),
    .illegal      (illegal)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_result(input rvga_reg got_rd, input rvga_word got_data,
                              input rvga_reg exp_rd, input rvga_word exp_data);
    if (got_rd !== exp_rd || got_data !== exp_data) begin
      stop_run($sformatf("ERROR at time %0t: result x%0d = %08h, expected x%0d = %08h",
                         $time, got_rd, got_data, exp_rd, exp_data));
    end
  endtask

  task automatic check_illegal(input logic got, input logic exp);
    if (got !== exp) begin
      stop_run($sformatf("ERROR at time %0t: illegal = %0b, expected %0b",
                         $time, got, exp));
    end
  endtask

  // The list ends at the first record whose flag column holds f
  function automatic int count_records();
    int n;
    n = 0;
    while (n < MAX_RECORDS && stim_mem[4*n+3] !== 32'hf) begin
      n++;
    end
    return (n < MAX_RECORDS) ? n : 0;
  endfunction

  task automatic drive_program();
    int         gap;
    exp_entry_t entry;
    for (int n = 0; n < num_lines; n++) begin
      gap = $urandom % 3;
      repeat (gap) begin
        @(posedge clk);
        instr_valid <= 1'b0;
      end
      @(posedge clk);
      instr_valid   <= 1'b1;
      instr         <= stim_mem[4*n];
      entry.illegal = stim_mem[4*n+3][0];
      entry.rd      = rvga_reg'(stim_mem[4*n+1]);
      entry.data    = stim_mem[4*n+2];
      exp_q.push_back(entry);
    end
    @(posedge clk);
    instr_valid <= 1'b0;
  endtask

  initial begin
    void'($urandom(50872));
    clk         = 1'b0;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    $readmemh("testbench/rvga_stim.txt", stim_mem);
    num_lines = count_records();
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    if (num_lines == 0) begin
      stop_run("The stimulus file holds no records or lacks its end marker");
    end else begin
      drive_program();
      repeat (5) @(negedge clk);  // Pipeline is three stages deep
      if (exp_q.size() != 0) begin
        stop_run($sformatf("%0d expected results never came out", exp_q.size()));
      end else begin
        $display("Done: no errors");
        $finish;
      end
    end
  end

  // Outputs settle after the rising edge, so they are sampled on the falling one
  always @(negedge clk) begin : monitor
    exp_entry_t entry;
    if (rst_n && (result_valid || illegal)) begin
      if (result_valid && illegal) begin
        stop_run("result_valid and illegal were high in the same cycle");
      end else if (exp_q.size() == 0) begin
        stop_run("Unexpected output pulse with no instruction pending");
      end else begin
        entry = exp_q.pop_front();
        check_illegal(illegal, entry.illegal);
        if (result_valid) begin
          check_result(result_rd, result_data, entry.rd, entry.data);
        end
      end
    end
  end

  initial begin : watchdog
    wait (num_lines > 0);
    #((num_lines * 3 + 10) * CLK_PERIOD);
    stop_run($sformatf("The run timed out after %0d cycles", num_lines * 3 + 10));
  end

endmodule : tb_rvga_core

/* testbench/rvga_stim.txt */
// instr    rd value    flag (0 result, 1 illegal, f end of list)
// illegal records carry rd 00 and value 00000000 as placeholders
FFB00093 01 FFFFFFFB 0
06400113 02 00000064 0
FFC0A193 03 00000001 0
FFF13213 04 00000001 0
0F00C293 05 FFFFFF0B 0
F0016313 06 FFFFFF64 0
7F037393 07 00000760 0
00411413 08 00000640 0
01C0D493 09 0000000F 0
4020D513 0A FFFFFFFE 0
41F35593 0B FFFFFFFF 0
40345613 0C 000000C8 0
800006B7 0D 80000000 0
12345737 0E 12345000 0
002707B3 0F 12345064 0
40D00833 10 80000000 0
0026A8B3 11 00000001 0
0026B933 12 00000000 0
00B0A9B3 13 00000001 0
0015BA33 14 00000000 0
00271AB3 15 23450000 0
0026DB33 16 08000000 0
4026DBB3 17 F8000000 0
017B4C33 18 F0000000 0
007C6CB3 19 F0000760 0
005CFD33 1A F0000700 0
001D0013 00 F0000701 0
01A00DB3 1B F0000700 0
100D8E13 1C F0000800 0
41BE0EB3 1D 00000100 0
01DE8463 00 00000000 1
01D12023 00 00000000 1
00012E83 00 00000000 1
01000EEF 00 00000000 1
001E8F13 1E 00000101 0
01E40FB3 1F 00000741 0
000100E7 00 00000000 1
41F080B3 01 FFFFF8BA 0
00000000 00 00000000 f

/* verilog.f */
hw/rvga_pkg.sv
hw/rvga_ifs.sv
hw/decode_stage.sv
hw/reg_fetch.sv
hw/alu_execute.sv
hw/rvga_core.sv
testbench/tb_rvga_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rvga_core
RTL_TOP   ?= rvga_core
LOG       ?= sim.log
SEED_ARGS ?= +verilator+seed+50872
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SRCS := $(shell cat verilog.f)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(SRCS) verilog.f
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f verilog.f

run: $(SIM)
	-./$(SIM) $(SEED_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Done: no errors$$" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f verilog.f

clean:
	rm -rf $(BUILD_DIR) $(LOG)
